//--- rtl/dcache_pkg.sv
package dcache_pkg;

    localparam int addr_w = 32;
    localparam int word_w = 32;
    localparam int words_per_line = 4;
    localparam int num_ways = 2;
    localparam int num_sets = 256;

    // 4 KiB per way, 16-byte lines
    localparam int byte_sel_w = $clog2(word_w / 8);
    localparam int word_sel_w = $clog2(words_per_line);
    localparam int index_w = $clog2(num_sets);
    localparam int offset_w = byte_sel_w + word_sel_w;
    localparam int tag_w = addr_w - index_w - offset_w;

    typedef logic [tag_w-1:0] tag_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [word_w/8-1:0] strb_t;
    typedef word_t [words_per_line-1:0] line_t; // word 0 in the low bits

    typedef struct packed {
        tag_t tag;
        logic valid;
        logic dirty;
    } tag_entry_t;

    typedef struct packed {
        logic op; // 1 = store
        logic [addr_w-1:0] addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr; // line aligned
        line_t line;
    } mem_req_t;

    function automatic tag_t addr_tag(input logic [addr_w-1:0] addr);
        return addr[addr_w-1 -: tag_w];
    endfunction

    function automatic index_t addr_index(input logic [addr_w-1:0] addr);
        return addr[offset_w +: index_w];
    endfunction

    function automatic logic [word_sel_w-1:0] addr_word(input logic [addr_w-1:0] addr);
        return addr[byte_sel_w +: word_sel_w];
    endfunction

    function automatic logic [addr_w-1:0] line_addr(input tag_t tag, input index_t index);
        return {tag, index, {offset_w{1'b0}}};
    endfunction

endpackage

//--- rtl/dcache_ram.sv
`timescale 1ns/1ps

module dcache_ram #(
    parameter type payload_t = logic [31:0],
    parameter int depth = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [depth];

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

//--- rtl/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays import dcache_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  index_t              raddr,
    input  tag_t                lookup_tag,
    input  logic                victim_way,
    input  logic [num_ways-1:0] we,
    input  index_t              waddr,
    input  tag_entry_t          wentry,
    input  line_t               wline,
    output logic [num_ways-1:0] hit,
    output logic                hit_way,
    output line_t               hit_line,
    output tag_entry_t          victim_entry,
    output line_t               victim_line,
    output logic                init_busy
);

    tag_entry_t tag_rd [num_ways];
    line_t      line_rd [num_ways];
    index_t     sweep_cnt;
    index_t     tag_waddr;
    tag_entry_t tag_wdata;

    // clear all valid bits after reset, one set per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            init_busy <= 1'b1;
            sweep_cnt <= '0;
        end else if (init_busy) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == index_t'(num_sets - 1)) begin
                init_busy <= 1'b0;
            end
        end
    end

    assign tag_waddr = init_busy ? sweep_cnt : waddr;
    assign tag_wdata = init_busy ? tag_entry_t'('0) : wentry;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        dcache_ram #(.payload_t(tag_entry_t), .depth(num_sets)) u_tag_ram (
            .clk   (clk),
            .we    (init_busy | we[w]),
            .waddr (tag_waddr),
            .wdata (tag_wdata),
            .raddr (raddr),
            .rdata (tag_rd[w])
        );

        dcache_ram #(.payload_t(line_t), .depth(num_sets)) u_data_ram (
            .clk   (clk),
            .we    (we[w]),
            .waddr (waddr),
            .wdata (wline),
            .raddr (raddr),
            .rdata (line_rd[w])
        );

        assign hit[w] = tag_rd[w].valid && (tag_rd[w].tag == lookup_tag);
    end

    assign hit_way      = hit[1]; // two ways only
    assign hit_line     = line_rd[hit_way];
    assign victim_entry = tag_rd[victim_way];
    assign victim_line  = line_rd[victim_way];

endmodule

//--- rtl/dcache_plru.sv
`timescale 1ns/1ps

module dcache_plru import dcache_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  index_t index,
    output logic   victim,
    input  logic   update,
    input  index_t upd_index,
    input  logic   used_way
);

    // one bit per set, names the least recently used way
    logic [num_sets-1:0] lru_bits;

    assign victim = lru_bits[index];

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (update) begin
            lru_bits[upd_index] <= ~used_way; // point at the other way
        end
    end

endmodule

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    // cpu side
    input  logic                req_valid,
    input  cpu_req_t            req,
    output logic                busy,
    output logic                rsp_valid,
    output word_t               rdata,
    // arrays
    output index_t              raddr,
    output tag_t                lookup_tag,
    output logic [num_ways-1:0] we,
    output index_t              waddr,
    output tag_entry_t          wentry,
    output line_t               wline,
    input  logic [num_ways-1:0] hit,
    input  logic                hit_way,
    input  line_t               hit_line,
    input  tag_entry_t          victim_entry,
    input  line_t               victim_line,
    input  logic                init_busy,
    // replacement state
    input  logic                victim,
    output logic                update,
    output index_t              upd_index,
    output logic                used_way,
    // memory side
    output logic                mem_rd_req,
    output logic [addr_w-1:0]   mem_rd_addr,
    input  logic                mem_rd_rdy,
    input  logic                mem_ret_valid,
    input  line_t               mem_ret_line,
    output logic                mem_wr_req,
    output mem_req_t            mem_wr,
    input  logic                mem_wr_rdy,
    input  logic                mem_wr_done
);

    typedef enum logic [2:0] {
        s_idle,
        s_tagrd,
        s_lookup,
        s_missdirty,
        s_writeback,
        s_missclean,
        s_refill,
        s_refilldone
    } state_t;

    state_t   state;
    state_t   state_next;
    cpu_req_t req_q;
    logic     busy_q;
    logic     accept;
    logic     done;
    tag_t     req_tag;
    index_t   req_index;
    logic [word_sel_w-1:0] req_word;
    word_t    hit_word;
    word_t    merged_word;
    line_t    merged_line;

    assign busy   = busy_q | init_busy;
    assign accept = req_valid & ~busy;
    assign done   = (state == s_lookup) & (|hit);

    assign req_tag   = addr_tag(req_q.addr);
    assign req_index = addr_index(req_q.addr);
    assign req_word  = addr_word(req_q.addr);

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (done) begin
            rdata <= hit_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= s_idle;
            busy_q    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            state     <= state_next;
            rsp_valid <= done;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle:       if (accept) state_next = s_tagrd;
            s_tagrd:      state_next = s_lookup;
            s_lookup: begin
                if (|hit) begin
                    state_next = s_idle;
                end else if (victim_entry.valid && victim_entry.dirty) begin
                    state_next = s_missdirty;
                end else begin
                    state_next = s_missclean;
                end
            end
            s_missdirty:  if (mem_wr_rdy) state_next = s_writeback;
            s_writeback:  if (mem_wr_done) state_next = s_missclean;
            s_missclean:  if (mem_rd_rdy) state_next = s_refill;
            s_refill:     if (mem_ret_valid) state_next = s_refilldone;
            s_refilldone: state_next = s_lookup; // re-read the refilled line
            default:      state_next = s_idle;
        endcase
    end

    // byte merge of a store into the hit word
    assign hit_word = hit_line[req_word];

    always_comb begin
        for (int b = 0; b < word_w / 8; b++) begin
            merged_word[8*b +: 8] = req_q.strb[b] ? req_q.wdata[8*b +: 8] : hit_word[8*b +: 8];
        end
        merged_line = hit_line;
        merged_line[req_word] = merged_word;
    end

    assign raddr      = req_index;
    assign lookup_tag = req_tag;
    assign waddr      = req_index;

    always_comb begin
        we     = '0;
        wentry = '{tag: req_tag, valid: 1'b1, dirty: 1'b0};
        wline  = mem_ret_line;
        if (state == s_refill && mem_ret_valid) begin
            we[victim] = 1'b1;
        end else if (done && req_q.op) begin
            we           = hit;
            wentry.dirty = 1'b1;
            wline        = merged_line;
        end
    end

    assign update    = done;
    assign upd_index = req_index;
    assign used_way  = hit_way;

    assign mem_rd_req  = (state == s_missclean);
    assign mem_rd_addr = line_addr(req_tag, req_index);
    assign mem_wr_req  = (state == s_missdirty);
    assign mem_wr.addr = line_addr(victim_entry.tag, req_index);
    assign mem_wr.line = victim_line;

endmodule

//--- rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  cpu_req_t          req,
    output logic              busy,
    output logic              rsp_valid,
    output word_t             rdata,
    output logic              mem_rd_req,
    output logic [addr_w-1:0] mem_rd_addr,
    input  logic              mem_rd_rdy,
    input  logic              mem_ret_valid,
    input  line_t             mem_ret_line,
    output logic              mem_wr_req,
    output mem_req_t          mem_wr,
    input  logic              mem_wr_rdy,
    input  logic              mem_wr_done
);

    index_t              raddr;
    tag_t                lookup_tag;
    logic [num_ways-1:0] we;
    index_t              waddr;
    tag_entry_t          wentry;
    line_t               wline;
    logic [num_ways-1:0] hit;
    logic                hit_way;
    line_t               hit_line;
    tag_entry_t          victim_entry;
    line_t               victim_line;
    logic                init_busy;
    logic                victim;
    logic                update;
    index_t              upd_index;
    logic                used_way;

    dcache_ctrl u_ctrl (.*);

    dcache_arrays u_arrays (
        .clk          (clk),
        .reset        (reset),
        .raddr        (raddr),
        .lookup_tag   (lookup_tag),
        .victim_way   (victim), // same set as the lookup
        .we           (we),
        .waddr        (waddr),
        .wentry       (wentry),
        .wline        (wline),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_line     (hit_line),
        .victim_entry (victim_entry),
        .victim_line  (victim_line),
        .init_busy    (init_busy)
    );

    dcache_plru u_plru (
        .clk       (clk),
        .reset     (reset),
        .index     (raddr),
        .victim    (victim),
        .update    (update),
        .upd_index (upd_index),
        .used_way  (used_way)
    );

endmodule

//--- verif/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk import dcache_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              busy,
    input logic              rsp_valid,
    input logic              mem_rd_req,
    input logic [addr_w-1:0] mem_rd_addr,
    input logic              mem_rd_rdy,
    input logic              mem_wr_req,
    input mem_req_t          mem_wr,
    input logic              mem_wr_rdy
);

    a_req_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_req && mem_wr_req))
        else $error("read and write requests high together");

    // request held until ready
    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req && !mem_rd_rdy |=> mem_rd_req && $stable(mem_rd_addr))
        else $error("read request changed before ready");

    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req && !mem_wr_rdy |=> mem_wr_req && $stable(mem_wr))
        else $error("write request changed before ready");

    a_rsp_pulse: assert property (@(posedge clk) disable iff (reset) rsp_valid |=> !rsp_valid)
        else $error("rsp_valid high for two cycles");

    a_busy: assert property (@(posedge clk) disable iff (reset)
        (mem_rd_req || mem_wr_req) |-> busy)
        else $error("memory request pending while not busy");

endmodule

bind dcache_top dcache_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .busy        (busy),
    .rsp_valid   (rsp_valid),
    .mem_rd_req  (mem_rd_req),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_rdy  (mem_rd_rdy),
    .mem_wr_req  (mem_wr_req),
    .mem_wr      (mem_wr),
    .mem_wr_rdy  (mem_wr_rdy)
);

//--- verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam logic [31:0] seed = 32'h7808;
    localparam int idle_limit = 400; // init sweep is 256 cycles
    localparam int rsp_limit = 200;
    localparam int num_random = 400;

    typedef struct packed {
        logic op;
        logic hit;
        word_t data;
        logic exp_wb;
        logic [addr_w-1:0] wb_addr;
        line_t wb_line;
        logic exp_rd;
        logic [addr_w-1:0] rd_addr;
        logic [31:0] acc_cycle;
    } expect_t;

    typedef struct packed {
        logic is_wr;
        logic [addr_w-1:0] addr;
        line_t line;
    } mem_event_t;

    logic clk, reset, req_valid;
    cpu_req_t req;
    logic busy, rsp_valid;
    word_t rdata;
    logic mem_rd_req, mem_rd_rdy, mem_ret_valid;
    logic [addr_w-1:0] mem_rd_addr;
    line_t mem_ret_line;
    logic mem_wr_req, mem_wr_rdy, mem_wr_done;
    mem_req_t mem_wr;

    logic [7:0] mem_bytes [logic [addr_w-1:0]];
    logic [7:0] shadow [logic [addr_w-1:0]]; // what the cpu should see
    expect_t expq [$];
    mem_event_t mem_log [$];
    logic [31:0] cycle_cnt = '0;
    int issued = 0;
    int rsp_count = 0;

    // lru model with one entry per set and way
    tag_t m_tag [num_sets][num_ways];
    logic m_valid [num_sets][num_ways];
    logic m_dirty [num_sets][num_ways];
    logic m_lru [num_sets];

    dcache_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic flag_mismatch(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic abort_on_timeout(input string msg);
        $display("timeout: %s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped on timeout");
    endtask

    function automatic logic [7:0] byte_at(input logic [addr_w-1:0] a, input logic from_shadow);
        logic [addr_w-1:0] h;
        h = a * 32'h9e37_79b1; // untouched bytes
        if (from_shadow && shadow.exists(a)) return shadow[a];
        if (!from_shadow && mem_bytes.exists(a)) return mem_bytes[a];
        return h[31:24] ^ h[15:8];
    endfunction

    // reference load result
    function automatic word_t expected_word(input logic [addr_w-1:0] a, input logic from_shadow);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = byte_at({a[addr_w-1:2], 2'b00} + 32'(b), from_shadow);
        end
        return w;
    endfunction

    function automatic line_t line_at(input logic [addr_w-1:0] a, input logic from_shadow);
        line_t l;
        for (int i = 0; i < words_per_line; i++) begin
            l[i] = expected_word(a + 32'(4 * i), from_shadow);
        end
        return l;
    endfunction

    function automatic logic [addr_w-1:0] make_addr(input tag_t tg, input index_t idx,
                                                    input logic [1:0] wd);
        return {tg, idx, wd, 2'b00};
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > idle_limit) abort_on_timeout("busy stayed high");
        end
    endtask

    task automatic access(input logic op, input logic [addr_w-1:0] addr, input word_t wdata,
                          input strb_t strb);
        expect_t e;
        index_t idx;
        tag_t tg;
        logic way;
        int n;
        idx = addr[offset_w +: index_w];
        tg = addr[addr_w-1 -: tag_w];
        e = '0;
        e.op = op;
        way = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                e.hit = 1'b1;
                way = w[0];
            end
        end
        if (!e.hit) begin
            way = m_lru[idx];
            e.exp_rd = 1'b1;
            e.rd_addr = {tg, idx, {offset_w{1'b0}}};
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                e.exp_wb = 1'b1;
                e.wb_addr = {m_tag[idx][way], idx, {offset_w{1'b0}}};
                e.wb_line = line_at(e.wb_addr, 1'b1);
            end
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way] = tg;
            m_dirty[idx][way] = 1'b0;
        end
        m_lru[idx] = ~way;
        if (op) begin
            m_dirty[idx][way] = 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[{addr[addr_w-1:2], 2'b00} + 32'(b)] = wdata[8*b +: 8];
            end
        end else begin
            e.data = expected_word(addr, 1'b1);
        end
        wait_idle();
        req_valid = 1'b1;
        req = '{op: op, addr: addr, wdata: wdata, strb: strb};
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        e.acc_cycle = cycle_cnt; // accepting edge
        expq.push_back(e);
        issued++;
        n = 0;
        while (rsp_count < issued) begin
            @(posedge clk);
            #1;
            n++;
            if (n > rsp_limit) abort_on_timeout("no response from the cache");
        end
    endtask

    task automatic random_store(input logic [addr_w-1:0] addr);
        access(1'b1, addr, word_t'($urandom()), strb_t'($urandom_range(0, 15)));
    endtask

    task automatic serve_read();
        mem_event_t ev;
        repeat ($urandom_range(0, 4)) begin
            @(posedge clk);
            #1;
        end
        mem_rd_rdy = 1'b1;
        ev = '{is_wr: 1'b0, addr: mem_rd_addr, line: '0};
        @(posedge clk);
        #1;
        mem_rd_rdy = 1'b0;
        mem_log.push_back(ev);
        repeat ($urandom_range(0, 4)) begin
            @(posedge clk);
            #1;
        end
        mem_ret_valid = 1'b1;
        mem_ret_line = line_at(ev.addr, 1'b0);
        @(posedge clk);
        #1;
        mem_ret_valid = 1'b0;
    endtask

    task automatic serve_write();
        mem_event_t ev;
        logic [8*16-1:0] flat;
        repeat ($urandom_range(0, 4)) begin
            @(posedge clk);
            #1;
        end
        mem_wr_rdy = 1'b1;
        ev = '{is_wr: 1'b1, addr: mem_wr.addr, line: mem_wr.line};
        @(posedge clk);
        #1;
        mem_wr_rdy = 1'b0;
        mem_log.push_back(ev);
        flat = ev.line;
        for (int i = 0; i < 16; i++) begin
            mem_bytes[ev.addr + 32'(i)] = flat[8*i +: 8];
        end
        repeat ($urandom_range(0, 4)) begin
            @(posedge clk);
            #1;
        end
        mem_wr_done = 1'b1;
        @(posedge clk);
        #1;
        mem_wr_done = 1'b0;
    endtask

    initial begin : mem_model
        mem_rd_rdy = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_line = '0;
        mem_wr_rdy = 1'b0;
        mem_wr_done = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_wr_req === 1'b1) serve_write();
            else if (mem_rd_req === 1'b1) serve_read();
        end
    end

    initial begin : compare
        expect_t e;
        int k;
        forever begin
            @(negedge clk);
            if (rsp_valid === 1'b1) begin
                assert (expq.size() > 0) else flag_mismatch("response with no request pending");
                e = expq.pop_front();
                assert (busy === 1'b0) else flag_mismatch("busy still high during the response");
                assert (e.op || rdata === e.data) else
                    flag_mismatch($sformatf("load data %h, expected %h", rdata, e.data));
                assert (!e.hit || cycle_cnt - e.acc_cycle == 32'd2) else
                    flag_mismatch($sformatf("hit took %0d cycles", cycle_cnt - e.acc_cycle));
                assert (mem_log.size() == int'(e.exp_wb) + int'(e.exp_rd)) else
                    flag_mismatch($sformatf("%0d memory requests, expected %0d",
                                            mem_log.size(), int'(e.exp_wb) + int'(e.exp_rd)));
                k = 0;
                if (e.exp_wb) begin
                    assert (mem_log[0].is_wr && mem_log[0].addr == e.wb_addr
                            && mem_log[0].line === e.wb_line) else
                        flag_mismatch($sformatf("write-back %h, expected %h with shadow line",
                                                mem_log[0].addr, e.wb_addr));
                    k = 1;
                end
                if (e.exp_rd) begin
                    assert (!mem_log[k].is_wr && mem_log[k].addr == e.rd_addr) else
                        flag_mismatch($sformatf("line read %h, expected %h",
                                                mem_log[k].addr, e.rd_addr));
                end
                mem_log.delete();
                rsp_count++;
            end
        end
    end

    initial begin : main
        tag_t tg;
        index_t idx;
        void'($urandom(seed));
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        for (int s = 0; s < num_sets; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < num_ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (rsp_valid === 1'b0 && mem_rd_req === 1'b0 && mem_wr_req === 1'b0) else
            flag_mismatch("cache outputs active after reset");
        wait_idle();
        // miss then hit on the same line
        access(1'b0, make_addr(20'h00001, 8'h23, 2'd1), '0, '0);
        access(1'b0, make_addr(20'h00001, 8'h23, 2'd2), '0, '0);
        for (int i = 0; i < 12; i++) begin
            random_store(make_addr(20'h00001, 8'h23, 2'(i)));
        end
        for (int i = 0; i < 4; i++) begin
            access(1'b0, make_addr(20'h00001, 8'h23, 2'(i)), '0, '0);
        end
        // three lines into set 0x57 for a clean and a dirty victim
        access(1'b0, make_addr(20'h00010, 8'h57, 2'd0), '0, '0);
        random_store(make_addr(20'h00011, 8'h57, 2'd3));
        access(1'b0, make_addr(20'h00012, 8'h57, 2'd1), '0, '0);
        access(1'b0, make_addr(20'h00010, 8'h57, 2'd2), '0, '0);
        access(1'b0, make_addr(20'h00011, 8'h57, 2'd3), '0, '0);
        for (int i = 0; i < num_random; i++) begin
            tg = tag_t'(32'h200 + $urandom_range(0, 3));
            idx = index_t'(32'h60 + $urandom_range(0, 3));
            if ($urandom_range(0, 1) == 1) begin
                random_store(make_addr(tg, idx, 2'($urandom_range(0, 3))));
            end else begin
                access(1'b0, make_addr(tg, idx, 2'($urandom_range(0, 3))), '0, '0);
            end
        end
        assert (busy === 1'b0 && mem_rd_req === 1'b0 && mem_wr_req === 1'b0) else
            flag_mismatch("cache not idle after the last response");
        $display("TEST OK");
        $finish;
    end

endmodule

//--- dcache_top.f
rtl/dcache_pkg.sv
rtl/dcache_ram.sv
rtl/dcache_arrays.sv
rtl/dcache_plru.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verif/dcache_chk.sv
verif/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
# exit status is nonzero when the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module dcache_tb -f dcache_top.f -o dcache_sim &&
./obj_dir/dcache_sim ||
{ echo "dcache simulation failed"; exit 1; }
